// ==== include/core_params.svh ====
// ****************************************
// Core parameters
// Widths, register count, reset address
// and the nop encoding of the RV32 core
// ****************************************
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN     32
`define CORE_NREGS    32
`define CORE_RESET_PC 32'h0000_0000
// addi x0, x0, 0
`define CORE_NOP      32'h0000_0013

`endif

// ==== src/isa_pkg.sv ====
// ****************************************
// Instruction-set types
// Words, register indices, major opcodes
// and the funct3 codes of the subset
// ****************************************
`include "core_params.svh"

package isa_pkg;

   typedef logic [`CORE_XLEN-1:0] word_t;
   typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

   // Major opcodes, bits 6:0
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_lui    = 7'b0110111,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111
   } opcode_t;

   // ALU function codes
   localparam logic [2:0] f3_add = 3'b000;
   localparam logic [2:0] f3_sll = 3'b001;
   localparam logic [2:0] f3_slt = 3'b010;
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_srl = 3'b101;
   localparam logic [2:0] f3_or  = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;

   // Branch conditions
   localparam logic [2:0] f3_beq = 3'b000;
   localparam logic [2:0] f3_bne = 3'b001;
   localparam logic [2:0] f3_blt = 3'b100;
   localparam logic [2:0] f3_bge = 3'b101;

endpackage

// ==== src/ctrl_pkg.sv ====
// ****************************************
// Core control types
// ALU operations and destination sources
// ****************************************
package ctrl_pkg;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_sll,
      alu_srl,
      // Operand b straight through, for lui
      alu_pass_b
   } alu_op_t;

   // Where the destination register value comes from
   typedef enum logic [1:0] {
      res_alu,
      res_mem,
      res_link
   } result_src_t;

endpackage

// ==== src/inst_decode.sv ====
// ****************************************
// Instruction decoder
// Field split, immediate build and control
// ****************************************
`timescale 1ns/1ps

module inst_decode (
   input  isa_pkg::word_t         inst,
   output isa_pkg::reg_idx_t      rs1,
   output isa_pkg::reg_idx_t      rs2,
   output isa_pkg::reg_idx_t      rd,
   output isa_pkg::word_t         imm,
   output ctrl_pkg::alu_op_t      alu_op,
   output logic                   alu_src_imm,
   output logic                   reg_write,
   output logic                   mem_read,
   output logic                   mem_write,
   output logic                   branch,
   output logic                   jump,
   output logic                   jump_reg,
   output ctrl_pkg::result_src_t  result_src,
   output logic [2:0]             funct3
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   opcode_t opcode;
   alu_op_t arith_op;
   logic    arith_ok;
   word_t   imm_i;
   word_t   imm_s;
   word_t   imm_b;
   word_t   imm_u;
   word_t   imm_j;

   assign opcode = opcode_t'(inst[6:0]);
   assign rd     = inst[11:7];
   assign funct3 = inst[14:12];
   assign rs1    = inst[19:15];
   assign rs2    = inst[24:20];

   // Immediate formats
   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign imm_u = {inst[31:12], 12'b0};
   assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   // Register and immediate arithmetic share funct3
   always_comb
   begin
      arith_ok = 1'b1;
      case (funct3)
         f3_add:  arith_op = (opcode == opc_op && inst[30]) ? alu_sub : alu_add;
         f3_sll:  arith_op = alu_sll;
         f3_slt:  arith_op = alu_slt;
         f3_xor:  arith_op = alu_xor;
         f3_srl:  arith_op = alu_srl;
         f3_or:   arith_op = alu_or;
         f3_and:  arith_op = alu_and;
         default:
         begin
            arith_op = alu_add;
            arith_ok = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      imm         = imm_i;
      alu_op      = alu_add;
      alu_src_imm = 1'b0;
      reg_write   = 1'b0;
      mem_read    = 1'b0;
      mem_write   = 1'b0;
      branch      = 1'b0;
      jump        = 1'b0;
      jump_reg    = 1'b0;
      result_src  = res_alu;
      case (opcode)
         opc_op:
         begin
            alu_op    = arith_op;
            reg_write = arith_ok;
         end
         opc_op_imm:
         begin
            alu_op      = arith_op;
            alu_src_imm = 1'b1;
            reg_write   = arith_ok;
         end
         opc_lui:
         begin
            imm         = imm_u;
            alu_op      = alu_pass_b;
            alu_src_imm = 1'b1;
            reg_write   = 1'b1;
         end
         opc_load:
         begin
            alu_src_imm = 1'b1;
            mem_read    = 1'b1;
            reg_write   = 1'b1;
            result_src  = res_mem;
         end
         opc_store:
         begin
            imm         = imm_s;
            alu_src_imm = 1'b1;
            mem_write   = 1'b1;
         end
         opc_branch:
         begin
            imm    = imm_b;
            branch = 1'b1;
         end
         opc_jal:
         begin
            imm        = imm_j;
            jump       = 1'b1;
            reg_write  = 1'b1;
            result_src = res_link;
         end
         opc_jalr:
         begin
            jump       = 1'b1;
            jump_reg   = 1'b1;
            reg_write  = 1'b1;
            result_src = res_link;
         end
         // Anything else behaves as a nop
         default:
         begin
            reg_write = 1'b0;
         end
      endcase
   end

   // One data access per instruction
   a_mem_excl: assert final (!(mem_read && mem_write));

endmodule

// ==== src/reg_file.sv ====
// ****************************************
// Register file
// Two read ports, one write port, x0 = 0
// ****************************************
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  logic               we,
   input  isa_pkg::reg_idx_t  ra1,
   input  isa_pkg::reg_idx_t  ra2,
   input  isa_pkg::reg_idx_t  wa,
   input  isa_pkg::word_t     wd,
   output isa_pkg::word_t     rd1,
   output isa_pkg::word_t     rd2
);
   import isa_pkg::*;

   word_t regs [`CORE_NREGS];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < `CORE_NREGS; i++)
            regs[i] <= '0;
      end
      else if (we && wa != '0)
      begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

   // x0 must survive every write pattern
   a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

// ==== src/alu_execute.sv ====
// ****************************************
// Execute stage
// Forwarding, ALU, branch test, jump target
// ****************************************
`timescale 1ns/1ps

module alu_execute (
   input  isa_pkg::word_t     pc,
   input  isa_pkg::word_t     rs1_val,
   input  isa_pkg::word_t     rs2_val,
   input  isa_pkg::word_t     imm,
   input  isa_pkg::word_t     fwd_val,
   input  logic               fwd_a,
   input  logic               fwd_b,
   input  ctrl_pkg::alu_op_t  alu_op,
   input  logic               alu_src_imm,
   input  logic               branch,
   input  logic               jump,
   input  logic               jump_reg,
   input  logic [2:0]         funct3,
   output isa_pkg::word_t     alu_out,
   output isa_pkg::word_t     store_val,
   output isa_pkg::word_t     target,
   output logic               redirect
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   word_t op_a;
   word_t op_b_reg;
   word_t op_b;
   word_t jump_sum;
   logic  eq;
   logic  lt;
   logic  taken;

   // Result-stage value overrides a stale register read
   assign op_a     = fwd_a ? fwd_val : rs1_val;
   assign op_b_reg = fwd_b ? fwd_val : rs2_val;
   assign op_b     = alu_src_imm ? imm : op_b_reg;

   assign store_val = op_b_reg;

   always_comb
   begin
      case (alu_op)
         alu_sub:    alu_out = op_a - op_b;
         alu_and:    alu_out = op_a & op_b;
         alu_or:     alu_out = op_a | op_b;
         alu_xor:    alu_out = op_a ^ op_b;
         alu_slt:    alu_out = word_t'($signed(op_a) < $signed(op_b));
         alu_sll:    alu_out = op_a << op_b[4:0];
         alu_srl:    alu_out = op_a >> op_b[4:0];
         alu_pass_b: alu_out = op_b;
         default:    alu_out = op_a + op_b;
      endcase
   end

   // Branches always compare the two registers
   assign eq = (op_a == op_b_reg);
   assign lt = ($signed(op_a) < $signed(op_b_reg));

   always_comb
   begin
      case (funct3)
         f3_beq:  taken = eq;
         f3_bne:  taken = !eq;
         f3_blt:  taken = lt;
         f3_bge:  taken = !lt;
         default: taken = 1'b0;
      endcase
   end

   assign redirect = jump || (branch && taken);

   // jalr clears bit 0 of rs1 + imm
   assign jump_sum = op_a + imm;
   assign target   = jump_reg ? (jump_sum & ~word_t'(1)) : (pc + imm);

   a_target_aligned: assert final (redirect !== 1'b1 || target[1:0] == 2'b00);

endmodule

// ==== src/result_select.sv ====
// ****************************************
// Result stage
// Holds the last stage, picks the rd value
// ****************************************
`timescale 1ns/1ps

module result_select (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   stall,
   input  isa_pkg::word_t         alu_out,
   input  isa_pkg::word_t         link,
   input  isa_pkg::word_t         mem_data,
   input  logic                   reg_write,
   input  isa_pkg::reg_idx_t      rd,
   input  ctrl_pkg::result_src_t  result_src,
   output logic                   wb_we,
   output isa_pkg::reg_idx_t      wb_rd,
   output isa_pkg::word_t         wb_val
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   word_t       w_alu;
   word_t       w_link;
   result_src_t w_src;
   logic        w_write;

   always_ff @(posedge clk)
   begin
      if (rst)
         w_write <= 1'b0;
      else if (!stall)
         w_write <= reg_write;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         w_alu  <= alu_out;
         w_link <= link;
         w_src  <= result_src;
         wb_rd  <= rd;
      end
   end

   // Load data arrives from memory during this cycle
   always_comb
   begin
      case (w_src)
         res_mem:  wb_val = mem_data;
         res_link: wb_val = w_link;
         default:  wb_val = w_alu;
      endcase
   end

   assign wb_we = w_write && (wb_rd != '0) && !stall;

endmodule

// ==== src/rv_core.sv ====
// ****************************************
// RV32 integer core, three stages
// Fetch, decode/execute, result
// ****************************************
`timescale 1ns/1ps
`include "core_params.svh"

module rv_core (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall,
   input  isa_pkg::word_t     inst_rdata,
   input  isa_pkg::word_t     data_rdata,
   output isa_pkg::word_t     inst_addr,
   output isa_pkg::word_t     data_addr,
   output isa_pkg::word_t     data_wdata,
   output logic               data_we,
   output logic               data_re,
   output logic               wb_valid,
   output isa_pkg::reg_idx_t  wb_rd,
   output isa_pkg::word_t     wb_data
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   // Fetch stage
   word_t pc;
   word_t f_inst;
   word_t f_pc;

   // Decode and execute
   reg_idx_t    rs1;
   reg_idx_t    rs2;
   reg_idx_t    rd;
   word_t       imm;
   alu_op_t     alu_op;
   result_src_t result_src;
   logic        alu_src_imm;
   logic        reg_write;
   logic        mem_read;
   logic        mem_write;
   logic        branch;
   logic        jump;
   logic        jump_reg;
   logic [2:0]  funct3;
   word_t       rs1_val;
   word_t       rs2_val;
   word_t       alu_out;
   word_t       store_val;
   word_t       target;
   word_t       link;
   logic        redirect;
   logic        fwd_a;
   logic        fwd_b;

   // Result stage
   logic  wb_we;
   word_t wb_val;

   assign inst_addr = pc;

   // A taken transfer squashes the word being fetched
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc     <= `CORE_RESET_PC;
         f_inst <= `CORE_NOP;
      end
      else if (!stall)
      begin
         pc     <= redirect ? target : pc + word_t'(4);
         f_inst <= redirect ? `CORE_NOP : inst_rdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
         f_pc <= pc;
   end

   inst_decode u_decode (
      .inst        (f_inst),
      .rs1         (rs1),
      .rs2         (rs2),
      .rd          (rd),
      .imm         (imm),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .reg_write   (reg_write),
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .branch      (branch),
      .jump        (jump),
      .jump_reg    (jump_reg),
      .result_src  (result_src),
      .funct3      (funct3)
   );

   reg_file u_regs (
      .clk (clk),
      .rst (rst),
      .we  (wb_we),
      .ra1 (rs1),
      .ra2 (rs2),
      .wa  (wb_rd),
      .wd  (wb_val),
      .rd1 (rs1_val),
      .rd2 (rs2_val)
   );

   // wb_we already excludes x0
   assign fwd_a = wb_we && (rs1 == wb_rd);
   assign fwd_b = wb_we && (rs2 == wb_rd);

   alu_execute u_exec (
      .pc          (f_pc),
      .rs1_val     (rs1_val),
      .rs2_val     (rs2_val),
      .imm         (imm),
      .fwd_val     (wb_val),
      .fwd_a       (fwd_a),
      .fwd_b       (fwd_b),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .branch      (branch),
      .jump        (jump),
      .jump_reg    (jump_reg),
      .funct3      (funct3),
      .alu_out     (alu_out),
      .store_val   (store_val),
      .target      (target),
      .redirect    (redirect)
   );

   assign data_addr  = alu_out;
   assign data_wdata = store_val;
   assign data_we    = mem_write && !stall;
   assign data_re    = mem_read && !stall;

   assign link = f_pc + word_t'(4);

   result_select u_result (
      .clk        (clk),
      .rst        (rst),
      .stall      (stall),
      .alu_out    (alu_out),
      .link       (link),
      .mem_data   (data_rdata),
      .reg_write  (reg_write),
      .rd         (rd),
      .result_src (result_src),
      .wb_we      (wb_we),
      .wb_rd      (wb_rd),
      .wb_val     (wb_val)
   );

   assign wb_valid = wb_we;
   assign wb_data  = wb_val;

endmodule

// ==== bench/clock_gen.sv ====
// ****************************************
// Testbench clock and reset
// 100 ns clock, reset high for 16 cycles
// ****************************************
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Released on a falling edge, away from the sampling edge
   initial
   begin
      rst = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// ==== bench/tb_core.sv ====
// ****************************************
// Testbench for the RV32 core
// Random program, memories, ISA model
// ****************************************
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;
   import isa_pkg::*;

   localparam int TIMEOUT   = 5000;
   localparam int HALT_IDX  = 95;
   localparam int HALT_ADDR = HALT_IDX * 4;

   logic     clk;
   logic     rst;
   logic     stall;
   word_t    inst_rdata;
   word_t    data_rdata;
   word_t    inst_addr;
   word_t    data_addr;
   word_t    data_wdata;
   logic     data_we;
   logic     data_re;
   logic     wb_valid;
   reg_idx_t wb_rd;
   word_t    wb_data;

   word_t    imem [128];
   word_t    dmem [16];
   logic     landing [128];
   logic [31:0] lfsr;
   logic     stall_en;
   logic     reset_checked;
   int       cyc;

   // Expected in-order events from the model
   reg_idx_t exp_rd [$];
   word_t    exp_val [$];
   word_t    st_addr [$];
   word_t    st_val [$];

   clock_gen u_clk (
      .clk (clk),
      .rst (rst)
   );

   rv_core DUT (
      .clk        (clk),
      .rst        (rst),
      .stall      (stall),
      .inst_rdata (inst_rdata),
      .data_rdata (data_rdata),
      .inst_addr  (inst_addr),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_we    (data_we),
      .data_re    (data_re),
      .wb_valid   (wb_valid),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data)
   );

   // Instruction memory reads combinationally
   assign inst_rdata = imem[inst_addr[8:2]];

   // Data memory, read data one cycle after data_re
   always @(posedge clk)
   begin
      if (data_we)
         dmem[data_addr[5:2]] <= data_wdata;
      if (data_re)
         data_rdata <= dmem[data_addr[5:2]];
   end

   task stop_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task value_mismatch(input string name, input word_t got, input word_t exp);
      $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
      stop_run();
   endtask

   task abort_with(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
         lfsr = lfsr ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
         r = {r[30:0], next_bit()};
      return r;
   endfunction

   function automatic word_t fill_word(input word_t addr);
      return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
   endfunction

   // Instruction encoders
   function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   task automatic build_program();
      int i;
      int pend;
      int off;
      int tgt;
      int jimm;
      logic [3:0] kind;
      logic [2:0] f3;
      logic [1:0] bsel;
      logic [11:0] imm;
      logic [19:0] uimm;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [4:0] rb;
      for (int k = 0; k < 128; k++)
      begin
         imem[k]    = `CORE_NOP;
         landing[k] = 1'b0;
      end
      for (int k = 0; k < 16; k++)
         dmem[k] = fill_word(k * 4);
      i    = 0;
      pend = -1;
      while (i < HALT_IDX)
      begin
         kind = take_bits(4);
         rd   = take_bits(3);
         rs1  = take_bits(3);
         rs2  = take_bits(3);
         f3   = take_bits(3);
         // sltu is outside the subset
         if (f3 == 3'b011)
            f3 = 3'b000;
         if (pend >= 0)
         begin
            imem[i] = enc_i(pend, 5'd0, 3'b010, rd, 7'h03);
            pend = -1;
         end
         else if (kind <= 4)
         begin
            imem[i] = enc_r((f3 == 3'b000 && take_bits(1)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
         end
         else if (kind == 8)
         begin
            uimm    = take_bits(20);
            imem[i] = {uimm, rd, 7'h37};
         end
         else if (kind == 9 || kind == 10)
         begin
            imem[i] = enc_i(take_bits(4) * 4, 5'd0, 3'b010, rd, 7'h03);
         end
         else if (kind == 11 || kind == 12)
         begin
            off = take_bits(4) * 4;
            imem[i] = enc_s(off, rs2, 5'd0);
            // Sometimes read the same word right back
            if (take_bits(1) && i + 1 < HALT_IDX)
               pend = off;
         end
         else if ((kind == 13 || kind == 14) && i <= 90)
         begin
            off = take_bits(1) ? 12 : 8;
            landing[i + off / 4] = 1'b1;
            bsel = take_bits(2);
            if (kind == 13)
               imem[i] = enc_b(off, rs2, rs1, {bsel[1], 1'b0, bsel[0]});
            else
               imem[i] = enc_j(off, rd);
         end
         else if (kind == 15 && i <= 88 && !landing[i + 1] && !landing[i + 2])
         begin
            // lui / addi builds the target, jalr takes it
            rb = take_bits(3);
            if (rb == 5'd0)
               rb = 5'd1;
            jimm = take_bits(1) * 4;
            tgt  = (i + 2) * 4 + (take_bits(1) ? 12 : 8);
            imem[i]     = {20'd0, rb, 7'h37};
            imem[i + 1] = enc_i(tgt - jimm, rb, 3'b000, rb, 7'h13);
            imem[i + 2] = enc_i(jimm, rb, 3'b000, rd, 7'h67);
            landing[tgt / 4] = 1'b1;
            i = i + 2;
         end
         else
         begin
            imm = take_bits(12);
            if (f3 == 3'b001 || f3 == 3'b101)
               imm[11:5] = 7'd0;
            imem[i] = enc_i(imm, rs1, f3, rd, 7'h13);
         end
         i++;
      end
      imem[HALT_IDX] = enc_j(21'd0, 5'd0);
   endtask

   function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b101:  return a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   // Architectural interpreter over the same images
   task automatic run_model();
      word_t xr [32];
      word_t mm [16];
      word_t pc;
      word_t nxt;
      word_t inst;
      word_t a;
      word_t b;
      word_t imm_i;
      word_t imm_s;
      word_t imm_b;
      word_t imm_j;
      word_t res;
      word_t ea;
      logic  wr;
      logic  tk;
      int    steps;
      for (int k = 0; k < 32; k++)
         xr[k] = '0;
      for (int k = 0; k < 16; k++)
         mm[k] = dmem[k];
      pc    = `CORE_RESET_PC;
      steps = 0;
      while (pc != HALT_ADDR && steps < 1000)
      begin
         inst  = imem[pc[8:2]];
         a     = xr[inst[19:15]];
         b     = xr[inst[24:20]];
         imm_i = {{20{inst[31]}}, inst[31:20]};
         imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
         imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
         nxt   = pc + 4;
         wr    = 1'b0;
         res   = '0;
         case (inst[6:0])
            7'h33:
            begin
               res = model_alu(inst[14:12], inst[30], a, b);
               wr  = 1'b1;
            end
            7'h13:
            begin
               res = model_alu(inst[14:12], 1'b0, a, imm_i);
               wr  = 1'b1;
            end
            7'h37:
            begin
               res = {inst[31:12], 12'd0};
               wr  = 1'b1;
            end
            7'h03:
            begin
               ea  = a + imm_i;
               res = mm[ea[5:2]];
               wr  = 1'b1;
            end
            7'h23:
            begin
               ea = a + imm_s;
               mm[ea[5:2]] = b;
               st_addr.push_back(ea);
               st_val.push_back(b);
            end
            7'h63:
            begin
               case (inst[14:12])
                  3'b000:  tk = (a == b);
                  3'b001:  tk = (a != b);
                  3'b100:  tk = ($signed(a) < $signed(b));
                  default: tk = ($signed(a) >= $signed(b));
               endcase
               if (tk)
                  nxt = pc + imm_b;
            end
            7'h6f:
            begin
               res = pc + 4;
               wr  = 1'b1;
               nxt = pc + imm_j;
            end
            7'h67:
            begin
               res = pc + 4;
               wr  = 1'b1;
               nxt = (a + imm_i) & ~32'd1;
            end
            default:
            begin
               wr = 1'b0;
            end
         endcase
         if (wr && inst[11:7] != 5'd0)
         begin
            xr[inst[11:7]] = res;
            exp_rd.push_back(inst[11:7]);
            exp_val.push_back(res);
         end
         pc = nxt;
         steps++;
      end
      assert (pc == HALT_ADDR)
         else abort_with("Model never reached the halt address");
   endtask

   task idle_check();
      assert (wb_valid === 1'b0) else value_mismatch("wb_valid", wb_valid, 0);
      assert (data_we === 1'b0) else value_mismatch("data_we", data_we, 0);
      assert (data_re === 1'b0) else value_mismatch("data_re", data_re, 0);
      assert (inst_addr === `CORE_RESET_PC)
         else value_mismatch("inst_addr", inst_addr, `CORE_RESET_PC);
   endtask

   // Outputs are sampled at the rising edge, inputs change at the falling one
   always @(posedge clk)
   begin
      cyc = cyc + 1;
      if (rst)
      begin
         if (cyc > 1)
            idle_check();
      end
      else
      begin
         if (!reset_checked)
         begin
            idle_check();
            reset_checked = 1'b1;
         end
         if (stall)
         begin
            assert (!wb_valid && !data_we && !data_re)
               else abort_with("A strobe was high while stall was high");
         end
         if (wb_valid)
         begin
            assert (exp_rd.size() > 0)
               else abort_with("Register write-back with none expected");
            assert (wb_rd == exp_rd[0]) else value_mismatch("wb_rd", wb_rd, exp_rd[0]);
            assert (wb_data == exp_val[0]) else value_mismatch("wb_data", wb_data, exp_val[0]);
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
         end
         if (data_we || data_re)
         begin
            assert (data_addr < 64 && data_addr[1:0] == 2'b00)
               else abort_with("Data access outside the 16-word data memory");
         end
         if (data_we)
         begin
            assert (st_addr.size() > 0)
               else abort_with("Store issued with none expected");
            assert (data_addr == st_addr[0])
               else value_mismatch("data_addr", data_addr, st_addr[0]);
            assert (data_wdata == st_val[0])
               else value_mismatch("data_wdata", data_wdata, st_val[0]);
            void'(st_addr.pop_front());
            void'(st_val.pop_front());
         end
      end
   end

   // About one cycle in six stalled
   always @(negedge clk)
   begin
      if (stall_en)
         stall = (take_bits(5) < 5);
      else
         stall = 1'b0;
   end

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      assert (!rst) else abort_with("Timed out waiting for reset release");
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((exp_rd.size() != 0 || st_addr.size() != 0) && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      assert (exp_rd.size() == 0 && st_addr.size() == 0)
         else abort_with("Timed out before all expected writes and stores were seen");
   endtask

   task automatic wait_halt_fetch();
      int n;
      n = 0;
      while (inst_addr !== HALT_ADDR && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      assert (inst_addr === HALT_ADDR)
         else abort_with("Timed out waiting for the fetch of the halt address");
   endtask

   initial
   begin
      stall         = 1'b0;
      data_rdata    = '0;
      stall_en      = 1'b0;
      reset_checked = 1'b0;
      cyc           = 0;
      lfsr          = 32'h7284_4d0a;
      build_program();
      run_model();
      wait_reset_release();
      stall_en = 1'b1;
      wait_drained();
      wait_halt_fetch();
      // Quiet period for stray writes or stores
      repeat (20) @(negedge clk);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+include
src/isa_pkg.sv
src/ctrl_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/alu_execute.sv
src/result_select.sv
src/rv_core.sv
bench/clock_gen.sv
bench/tb_core.sv
